// File: mips_mem_consts.svh
`ifndef MIPS_MEM_CONSTS_SVH
`define MIPS_MEM_CONSTS_SVH

// data ram size in 32-bit words
`define DRAM_DEPTH 4096

// word index width, log2 of the depth
`define DRAM_AW 12

// words in each preloaded region
`define INIT_LEN 29

// step of the arithmetic series region
`define INIT_STEP 32'hdcba1234

// byte address where the all-ones region begins
`define ONES_BASE 32'h100

`endif

// File: mips_mem_pkg.sv
package mips_mem_pkg;

    // load/store operation codes
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } mem_op_t;

    // one bus word, seen as byte lanes or halfword lanes
    // lane 0 sits in bits 7:0 for both views
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

endpackage

// File: data_bus_if.sv
`timescale 1ns/100ps
`include "mips_mem_consts.svh"

interface data_bus_if;
    import mips_mem_pkg::*;

    // word index, not a byte address
    logic [`DRAM_AW-1:0] word_addr;
    // read is a level, write a single-cycle strobe
    logic                read;
    logic                write;
    // one enable per byte lane
    logic [3:0]          byte_en;
    data_word_u          writedata;
    data_word_u          readdata;

    modport lsu (
        output word_addr,
        output read,
        output write,
        output byte_en,
        output writedata,
        input  readdata
    );

    modport ram (
        input  word_addr,
        input  read,
        input  write,
        input  byte_en,
        input  writedata,
        output readdata
    );

endinterface

// File: mips_lsu.sv
`timescale 1ns/100ps
`include "mips_mem_consts.svh"

module mips_lsu (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_valid,
    input  mips_mem_pkg::mem_op_t op,
    input  logic [31:0]           addr,
    input  logic [31:0]           store_data,
    output logic [31:0]           load_data,
    output logic                  misaligned,
    output logic                  fault_valid,
    output logic [31:0]           fault_addr,
    data_bus_if.lsu               bus
);
    import mips_mem_pkg::*;

    logic        is_load;
    logic        is_store;
    logic        is_half;
    logic        is_word;
    logic        bad_align;
    logic        out_of_range;
    logic        load_ok;
    logic        store_ok;
    logic [31:0] store_be;
    logic [31:0] store_swapped;
    logic [3:0]  store_lanes;
    data_word_u  load_word;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] load_ext;

    // op class decode
    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (op)
            LB, LBU: is_load = 1'b1;
            LH, LHU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            LW: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            SB: is_store = 1'b1;
            SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            default: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
        endcase
    end

    // alignment and range checks
    assign bad_align    = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));
    assign out_of_range = addr >= 32'(4 * `DRAM_DEPTH);
    assign misaligned   = op_valid && (bad_align || out_of_range);

    // a faulting op never reaches the ram
    assign load_ok  = op_valid && is_load && !misaligned;
    assign store_ok = op_valid && is_store && !misaligned;

    assign bus.word_addr = addr[`DRAM_AW+1:2];
    assign bus.read      = load_ok;
    assign bus.write     = store_ok;

    // replicate store data over the lanes, big-endian order
    // byte at offset k lands in lane k after the swap
    always_comb begin
        case (op)
            SB: begin
                store_be    = {4{store_data[7:0]}};
                store_lanes = 4'b0001 << addr[1:0];
            end
            SH: begin
                store_be    = {2{store_data[15:0]}};
                store_lanes = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_be    = store_data;
                store_lanes = 4'b1111;
            end
        endcase
    end

    // ram keeps words byte-reversed
    assign store_swapped = {<<8{store_be}};
    assign bus.writedata = store_swapped;
    assign bus.byte_en   = store_ok ? store_lanes : 4'b0000;

    // back to big-endian, offset 0 is the top byte
    assign load_word = {<<8{bus.readdata}};
    assign load_byte = load_word.bytes[~addr[1:0]];
    assign load_half = load_word.halves[~addr[1]];

    // sign or zero extension
    always_comb begin
        case (op)
            LB:      load_ext = {{24{load_byte[7]}}, load_byte};
            LBU:     load_ext = {24'h0, load_byte};
            LH:      load_ext = {{16{load_half[15]}}, load_half};
            LHU:     load_ext = {16'h0, load_half};
            default: load_ext = load_word;
        endcase
    end

    // zero whenever no load goes through
    assign load_data = load_ok ? load_ext : 32'h0;

    // sticky fault flag, only reset clears it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fault_valid <= 1'b0;
        end else if (misaligned) begin
            fault_valid <= 1'b1;
        end
    end

    // first faulting address, held afterwards
    always_ff @(posedge clk) begin
        if (misaligned && !fault_valid) begin
            fault_addr <= addr;
        end
    end

endmodule

// File: mips_dram.sv
`timescale 1ns/100ps
`include "mips_mem_consts.svh"

module mips_dram (
    input logic     clk,
    data_bus_if.ram bus
);

    // one word per entry, lane 0 in bits 7:0
    logic [3:0][7:0] ram [0:`DRAM_DEPTH-1];

    // power-up image
    initial begin
        logic [31:0] series_raw;
        logic [31:0] series_val;

        for (int w = 0; w < `DRAM_DEPTH; w++) begin
            ram[w] = 32'h0;
        end

        // arithmetic series, multiplier starts at 2
        // top bit cleared so every value is positive
        for (int k = 0; k < `INIT_LEN; k++) begin
            series_raw = `INIT_STEP * (k + 2) + 1;
            series_val = {1'b0, series_raw[30:0]};
            ram[k]     = {<<8{series_val}};
        end

        // all ones, same in either byte order
        for (int k = 0; k < `INIT_LEN; k++) begin
            ram[(`ONES_BASE >> 2) + k] = 32'hffff_ffff;
        end
    end

    // combinational read while read is high
    always_comb begin
        if (bus.read) begin
            bus.readdata = ram[bus.word_addr];
        end else begin
            bus.readdata = 32'h0;
        end
    end

    // per-lane write on the edge
    always_ff @(posedge clk) begin
        if (bus.write) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus.byte_en[lane]) begin
                    ram[bus.word_addr][lane] <= bus.writedata.bytes[lane];
                end
            end
        end
    end

endmodule

// File: mips_mem_top.sv
`timescale 1ns/100ps

module mips_mem_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op_valid,
    input  mips_mem_pkg::mem_op_t op,
    input  logic [31:0]           addr,
    input  logic [31:0]           store_data,
    output logic [31:0]           load_data,
    output logic                  misaligned,
    output logic                  fault_valid,
    output logic [31:0]           fault_addr
);

    // lsu to ram word bus
    data_bus_if bus ();

    // decode, alignment, endian swap, fault capture
    mips_lsu u_lsu (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .addr        (addr),
        .store_data  (store_data),
        .load_data   (load_data),
        .misaligned  (misaligned),
        .fault_valid (fault_valid),
        .fault_addr  (fault_addr),
        .bus         (bus.lsu)
    );

    // byte-reversed word storage
    mips_dram u_dram (
        .clk (clk),
        .bus (bus.ram)
    );

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen (
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);

    // power-on reset length in clock cycles
    localparam int RESET_CYCLES = 16;

    int   por_count = 0;
    logic rst_q     = 1'b0;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // low during the power-on window or while the testbench asks for it
    always @(posedge clk) begin
        if (por_count < RESET_CYCLES) begin
            por_count <= por_count + 1;
        end
        rst_q <= (por_count >= RESET_CYCLES - 1) && !reset_req;
    end

    assign rst_n = rst_q;

endmodule

// File: tb_mips_mem.sv
`timescale 1ns/100ps
`include "mips_mem_consts.svh"

module tb_mips_mem;
    import mips_mem_pkg::*;

    // roughly four times the summed length of all tests
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        reset_req;
    logic        op_valid;
    mem_op_t     op;
    logic [31:0] addr;
    logic [31:0] store_data;
    logic [31:0] load_data;
    logic        misaligned;
    logic        fault_valid;
    logic [31:0] fault_addr;

    // big-endian copy of memory, offset 0 in bits 31:24
    logic [31:0] ref_mem [0:`DRAM_DEPTH-1];
    int          error_count = 0;
    int          cycle_count = 0;

    tb_clk_gen u_clk_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    mips_mem_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .addr        (addr),
        .store_data  (store_data),
        .load_data   (load_data),
        .misaligned  (misaligned),
        .fault_valid (fault_valid),
        .fault_addr  (fault_addr)
    );

    task automatic check_word(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // power-up image: series region then all-ones region
    function automatic void build_reference();
        logic [31:0] raw;
        for (int w = 0; w < `DRAM_DEPTH; w++) begin
            ref_mem[w] = 32'h0;
        end
        for (int k = 0; k < `INIT_LEN; k++) begin
            raw = `INIT_STEP * (k + 2) + 1;
            ref_mem[k] = {1'b0, raw[30:0]};
            ref_mem[(`ONES_BASE / 4) + k] = 32'hffff_ffff;
        end
    endfunction

    function automatic logic [31:0] expect_load(mem_op_t o, logic [31:0] a);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] result;
        w = ref_mem[a[`DRAM_AW+1:2]];
        case (a[1:0])
            2'd0:    b = w[31:24];
            2'd1:    b = w[23:16];
            2'd2:    b = w[15:8];
            default: b = w[7:0];
        endcase
        h = a[1] ? w[15:0] : w[31:16];
        case (o)
            LB:      result = {{24{b[7]}}, b};
            LBU:     result = {24'h0, b};
            LH:      result = {{16{h[15]}}, h};
            LHU:     result = {16'h0, h};
            default: result = w;
        endcase
        return result;
    endfunction

    // only the addressed bytes change
    function automatic void update_reference(mem_op_t o, logic [31:0] a, logic [31:0] d);
        logic [31:0] w;
        w = ref_mem[a[`DRAM_AW+1:2]];
        case (o)
            SB: begin
                case (a[1:0])
                    2'd0:    w[31:24] = d[7:0];
                    2'd1:    w[23:16] = d[7:0];
                    2'd2:    w[15:8]  = d[7:0];
                    default: w[7:0]   = d[7:0];
                endcase
            end
            SH: begin
                if (a[1]) begin
                    w[15:0] = d[15:0];
                end else begin
                    w[31:16] = d[15:0];
                end
            end
            default: w = d;
        endcase
        ref_mem[a[`DRAM_AW+1:2]] = w;
    endfunction

    // one op per cycle, results sampled at the falling edge
    task automatic issue(mem_op_t o, logic [31:0] a, logic [31:0] d);
        @(posedge clk);
        op_valid   <= 1'b1;
        op         <= o;
        addr       <= a;
        store_data <= d;
        @(negedge clk);
    endtask

    task automatic go_idle();
        @(posedge clk);
        op_valid <= 1'b0;
        @(negedge clk);
        check_flag("idle misaligned", 1'b0, misaligned);
        check_word("idle load_data", 32'h0, load_data);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        op_valid  <= 1'b0;
        reset_req <= 1'b1;
        while (rst_n) @(posedge clk);
        reset_req <= 1'b0;
        while (!rst_n) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic load_and_check(string test, mem_op_t o, logic [31:0] a);
        issue(o, a, 32'h0);
        check_flag($sformatf("%s misaligned @%h", test, a), 1'b0, misaligned);
        check_word($sformatf("%s %s @%h", test, o.name(), a), expect_load(o, a), load_data);
    endtask

    task automatic store_and_check(mem_op_t o, logic [31:0] a, logic [31:0] d);
        issue(o, a, d);
        check_flag($sformatf("store %s misaligned @%h", o.name(), a), 1'b0, misaligned);
        check_word("store load_data", 32'h0, load_data);
        update_reference(o, a, d);
        // read back the whole word on the next cycle
        load_and_check($sformatf("store %s", o.name()), LW, {a[31:2], 2'b00});
    endtask

    task automatic test_initial_image();
        check_flag("image fault_valid after reset", 1'b0, fault_valid);
        for (int k = 0; k < `INIT_LEN; k++) begin
            load_and_check("image series", LW, 32'(k * 4));
            load_and_check("image ones", LW, `ONES_BASE + 32'(k * 4));
        end
    endtask

    task automatic test_subword_loads();
        logic [31:0] base;
        for (int k = 0; k < `INIT_LEN + 4; k++) begin
            // every series word, then a few ones words
            base = (k < `INIT_LEN) ? 32'(k * 4) : `ONES_BASE + 32'((k - `INIT_LEN) * 36);
            for (int off = 0; off < 4; off++) begin
                load_and_check("subword", LB, base + 32'(off));
                load_and_check("subword", LBU, base + 32'(off));
            end
            for (int off = 0; off < 4; off += 2) begin
                load_and_check("subword", LH, base + 32'(off));
                load_and_check("subword", LHU, base + 32'(off));
            end
        end
    endtask

    task automatic test_stores();
        logic [31:0] sel;
        logic [31:0] widx;
        logic [31:0] off;
        mem_op_t     o;
        for (int i = 0; i < 16; i++) begin
            sel = $urandom % 3;
            // half of the stores land among preloaded neighbours
            if ($urandom % 2 == 0) begin
                widx = $urandom % `INIT_LEN;
            end else begin
                widx = $urandom % `DRAM_DEPTH;
            end
            off = $urandom % 4;
            case (sel)
                0: o = SB;
                1: begin
                    o   = SH;
                    off = off & 32'h2;
                end
                default: begin
                    o   = SW;
                    off = 32'h0;
                end
            endcase
            store_and_check(o, (widx << 2) | off, $urandom);
        end
    endtask

    task automatic test_misaligned();
        issue(LH, 32'h5, 32'h0);
        check_flag("misaligned lh", 1'b1, misaligned);
        check_word("misaligned lh load_data", 32'h0, load_data);
        issue(SW, 32'ha, 32'hdead_beef);
        check_flag("misaligned sw", 1'b1, misaligned);
        go_idle();
        // suppressed store leaves the word alone
        load_and_check("misaligned", LW, 32'h8);
        check_flag("misaligned fault_valid", 1'b1, fault_valid);
        check_word("misaligned fault_addr", 32'h5, fault_addr);
    endtask

    task automatic test_out_of_range();
        pulse_reset();
        check_flag("range fault_valid after reset", 1'b0, fault_valid);
        issue(SW, 32'h4000, 32'h1234_5678);
        check_flag("range sw misaligned", 1'b1, misaligned);
        check_flag("range fault_valid same cycle", 1'b0, fault_valid);
        issue(LB, 32'h8000_0001, 32'h0);
        check_flag("range lb misaligned", 1'b1, misaligned);
        check_word("range lb load_data", 32'h0, load_data);
        check_flag("range fault_valid", 1'b1, fault_valid);
        check_word("range first fault_addr", 32'h4000, fault_addr);
        go_idle();
        check_word("range fault_addr held", 32'h4000, fault_addr);
        // 32'h4000 would alias word 0 if the store got through
        load_and_check("range", LW, 32'h0);
        pulse_reset();
        check_flag("range fault_valid cleared", 1'b0, fault_valid);
    endtask

    // hang guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run went past %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'ha5e4));
        reset_req  = 1'b0;
        op_valid   = 1'b0;
        op         = LW;
        addr       = 32'h0;
        store_data = 32'h0;
        build_reference();
        // first edge before looking at rst_n
        @(posedge clk);
        while (rst_n !== 1'b1) @(posedge clk);
        @(negedge clk);
        test_initial_image();
        test_subword_loads();
        test_stores();
        test_misaligned();
        test_out_of_range();
        go_idle();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: mips_mem_top.f
+incdir+.
mips_mem_pkg.sv
data_bus_if.sv
mips_lsu.sv
mips_dram.sv
mips_mem_top.sv
tb_clk_gen.sv
tb_mips_mem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f mips_mem_top.f --top-module tb_mips_mem -o sim_mips_mem
./obj_dir/sim_mips_mem > sim.log
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
